// ==== bench/tb_bus_tasks.svh ====
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// ----------------------------------------------------------------------
// Limits in clock cycles, bookkeeping
// ----------------------------------------------------------------------
localparam int ACK_TIMEOUT = 16;
localparam int IRQ_TIMEOUT = 200;

logic [31:0] lfsr_state;
string       test_name;
int          err_count = 0;
int          err_at_start = 0;
int          pass_count = 0;
int          fail_count = 0;

task automatic start_test(input string name);
	test_name = name;
	err_at_start = err_count;
endtask

// One line per finished test
task automatic end_test();
	if (err_count == err_at_start) begin
		pass_count++;
		$display("test %s ok", test_name);
	end else begin
		fail_count++;
		$display("test %s failed with %0d errors", test_name, err_count - err_at_start);
	end
endtask

task automatic report_problem(input string what);
	err_count++;
	$display("[ERROR] %s: %s", test_name, what);
endtask

task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
	assert (got === exp)
	else begin
		err_count++;
		$display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, got);
	end
endtask

// ----------------------------------------------------------------------
// Random bits, x^32 + x^22 + x^2 + x + 1
// ----------------------------------------------------------------------
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

// One LFSR step per bit taken
task automatic take_random(input int nbits, output logic [31:0] val);
	int i;
	val = '0;
	for (i = 0; i < nbits; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		val = {val[30:0], lfsr_state[0]};
	end
endtask

// Byte address from bank and register offset
function automatic logic [31:0] csr_addr(input logic [3:0] bank, input logic [3:0] ofs);
	return {16'h0000, bank, 6'b000000, ofs, 2'b00};
endfunction

// ----------------------------------------------------------------------
// Bus access and interrupt waits
// ----------------------------------------------------------------------
task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata);
	int waited;
	bit acked;
	waited = 0;
	acked = 1'b0;
	rdata = '0;
	@(posedge sys_clk);
	wb_adr_i <= addr;
	wb_dat_i <= wdata;
	wb_we_i <= we;
	wb_cyc_i <= 1'b1;
	wb_stb_i <= 1'b1;
	while (!acked && waited < ACK_TIMEOUT) begin
		@(posedge sys_clk);
		waited++;
		if (wb_ack_o === 1'b1) begin
			acked = 1'b1;
			rdata = wb_dat_o;
		end
	end
	// Drop the strobe on the ack edge
	wb_cyc_i <= 1'b0;
	wb_stb_i <= 1'b0;
	wb_we_i <= 1'b0;
	if (!acked)
		report_problem($sformatf("no bus ack within %0d cycles at address %h", ACK_TIMEOUT, addr));
endtask

task automatic read_check(input string what, input logic [31:0] addr, input logic [31:0] exp);
	logic [31:0] rdata;
	bus_access(1'b0, addr, 32'h0, rdata);
	check_value(what, exp, rdata);
endtask

task automatic wait_for_irq(input int idx, input int limit, output bit seen);
	int waited;
	seen = 1'b0;
	waited = 0;
	while (!seen && waited < limit) begin
		@(posedge sys_clk);
		waited++;
		if (irq_o[idx] === 1'b1)
			seen = 1'b1;
	end
endtask

`endif

// ==== bench/tb_sysctl_soc.sv ====
`default_nettype none

module tb_sysctl_soc
	import soc_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FLASH_TIMEOUT = 300;
	localparam int PERIPH_TIMEOUT = 1300;

	logic                  sys_clk;
	logic                  trigger_reset;
	logic [WB_ADDR_W-1:0]  wb_adr_i;
	logic [DATA_W-1:0]     wb_dat_i;
	logic                  wb_cyc_i;
	logic                  wb_stb_i;
	logic                  wb_we_i;
	logic [DATA_W-1:0]     wb_dat_o;
	logic                  wb_ack_o;
	logic [GPIO_IN_W-1:0]  gpio_inputs_i;
	logic [GPIO_OUT_W-1:0] gpio_outputs_o;
	logic [IRQ_W-1:0]      irq_o;
	logic                  flash_rst_n_o;
	logic                  periph_rst_n_o;

	`include "tb_bus_tasks.svh"

	sysctl_soc uut (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.wb_adr_i       (wb_adr_i),
		.wb_dat_i       (wb_dat_i),
		.wb_cyc_i       (wb_cyc_i),
		.wb_stb_i       (wb_stb_i),
		.wb_we_i        (wb_we_i),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o),
		.gpio_inputs_i  (gpio_inputs_i),
		.gpio_outputs_o (gpio_outputs_o),
		.irq_o          (irq_o),
		.flash_rst_n_o  (flash_rst_n_o),
		.periph_rst_n_o (periph_rst_n_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// ----------------------------------------------------------------------
	// Ack timing, counted from the edge that first samples the strobe
	// ----------------------------------------------------------------------
	property write_ack_timing;
		@(posedge sys_clk) disable iff (periph_rst_n_o !== 1'b1)
			$rose(wb_cyc_i && wb_stb_i) && wb_we_i |->
				##1 !wb_ack_o ##1 wb_ack_o ##1 !wb_ack_o;
	endproperty

	property read_ack_timing;
		@(posedge sys_clk) disable iff (periph_rst_n_o !== 1'b1)
			$rose(wb_cyc_i && wb_stb_i) && !wb_we_i |->
				##1 !wb_ack_o [*2] ##1 wb_ack_o ##1 !wb_ack_o;
	endproperty

	write_ack_check: assert property (write_ack_timing)
		else report_problem("write ack not exactly 2 edges after strobe or longer than one cycle");

	read_ack_check: assert property (read_ack_timing)
		else report_problem("read ack not exactly 3 edges after strobe or longer than one cycle");

	// ----------------------------------------------------------------------
	// Stimulus sequence
	// ----------------------------------------------------------------------
	initial begin
		logic [31:0]          rnd;
		logic [31:0]          cmp;
		logic [GPIO_IN_W-1:0] pattern;
		int                   waited;
		bit                   seen;

		trigger_reset <= 1'b1;
		wb_adr_i <= '0;
		wb_dat_i <= '0;
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i <= 1'b0;
		gpio_inputs_i <= 7'h05;
		lfsr_state = 32'h150e_f84f;

		start_test("reset_ordering");
		repeat (5) @(posedge sys_clk);
		check_value("flash_rst_n_o in reset", 32'h0, 32'(flash_rst_n_o));
		check_value("periph_rst_n_o in reset", 32'h0, 32'(periph_rst_n_o));
		check_value("wb_ack_o in reset", 32'h0, 32'(wb_ack_o));
		check_value("irq_o in reset", 32'h0, 32'(irq_o));
		check_value("gpio_outputs_o in reset", 32'h0, 32'(gpio_outputs_o));
		trigger_reset <= 1'b0;
		waited = 0;
		while (flash_rst_n_o !== 1'b1 && waited < FLASH_TIMEOUT) begin
			@(posedge sys_clk);
			waited++;
		end
		if (flash_rst_n_o !== 1'b1)
			report_problem("flash reset was not released within its timeout");
		else
			check_value("periph_rst_n_o at flash release", 32'h0, 32'(periph_rst_n_o));
		waited = 0;
		while (periph_rst_n_o !== 1'b1 && waited < PERIPH_TIMEOUT) begin
			@(posedge sys_clk);
			waited++;
		end
		if (periph_rst_n_o !== 1'b1)
			report_problem("system reset was not released within its timeout");
		end_test();

		start_test("bridge_id_read");
		read_check("system id", csr_addr(CSR_BANK_SYSCTL, REG_SYSTEM_ID), 32'h4D4F_4E45);
		read_check("other bank", csr_addr(4'd2, REG_SYSTEM_ID), 32'h0);
		end_test();

		start_test("gpio_outputs");
		take_random(GPIO_OUT_W, rnd);
		bus_access(1'b1, csr_addr(CSR_BANK_SYSCTL, REG_GPIO_OUT), rnd, cmp);
		check_value("gpio_outputs_o", rnd, 32'(gpio_outputs_o));
		read_check("gpio out readback", csr_addr(CSR_BANK_SYSCTL, REG_GPIO_OUT), rnd);
		end_test();

		start_test("gpio_inputs_irq");
		take_random(GPIO_IN_W, rnd);
		pattern = rnd[GPIO_IN_W-1:0];
		@(posedge sys_clk);
		gpio_inputs_i <= pattern;
		// Longer than the two-flop synchronizer
		repeat (4) @(posedge sys_clk);
		read_check("gpio in readback", csr_addr(CSR_BANK_SYSCTL, REG_GPIO_IN), 32'(pattern));
		bus_access(1'b1, csr_addr(CSR_BANK_SYSCTL, REG_GPIO_IRQ_EN), 32'h10, rnd);
		@(posedge sys_clk);
		gpio_inputs_i <= pattern ^ 7'h10;
		wait_for_irq(0, 10, seen);
		if (!seen)
			report_problem("no gpio interrupt after an enabled input changed");
		repeat (3) @(posedge sys_clk);
		// Bit 0 is masked off
		gpio_inputs_i <= pattern ^ 7'h11;
		wait_for_irq(0, 12, seen);
		check_value("irq after masked input change", 32'h0, 32'(seen));
		end_test();

		start_test("timer_one_shot");
		take_random(6, cmp);
		if (cmp < 8)
			cmp = cmp + 8;
		bus_access(1'b1, csr_addr(CSR_BANK_SYSCTL, REG_TIMER_COMPARE), cmp, rnd);
		bus_access(1'b1, csr_addr(CSR_BANK_SYSCTL, REG_TIMER_CTRL), 32'h1, rnd);
		wait_for_irq(1, IRQ_TIMEOUT, seen);
		if (!seen)
			report_problem("one-shot timer gave no interrupt within its timeout");
		read_check("ctrl after one-shot", csr_addr(CSR_BANK_SYSCTL, REG_TIMER_CTRL), 32'h0);
		read_check("counter after one-shot", csr_addr(CSR_BANK_SYSCTL, REG_TIMER_COUNTER),
			32'h0);
		end_test();

		start_test("timer_autorestart");
		bus_access(1'b1, csr_addr(CSR_BANK_SYSCTL, REG_TIMER_CTRL), 32'h3, rnd);
		wait_for_irq(1, IRQ_TIMEOUT, seen);
		if (!seen)
			report_problem("first autorestart interrupt missing within its timeout");
		wait_for_irq(1, IRQ_TIMEOUT, seen);
		if (!seen)
			report_problem("second autorestart interrupt missing within its timeout");
		read_check("ctrl while autorestart", csr_addr(CSR_BANK_SYSCTL, REG_TIMER_CTRL), 32'h3);
		bus_access(1'b1, csr_addr(CSR_BANK_SYSCTL, REG_TIMER_CTRL), 32'h0, rnd);
		end_test();

		repeat (2) @(posedge sys_clk);
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/csr_bridge.sv ====
`default_nettype none

module csr_bridge
	import soc_pkg::*;
(
	input  wire                  sys_clk,
	input  wire                  sys_rst_i,

	// Classic bus slave port
	input  wire [WB_ADDR_W-1:0]  wb_adr_i,
	input  wire [DATA_W-1:0]     wb_dat_i,
	input  wire                  wb_cyc_i,
	input  wire                  wb_stb_i,
	input  wire                  wb_we_i,
	output logic [DATA_W-1:0]    wb_dat_o,
	output logic                 wb_ack_o,

	// CSR master side
	csr_if.bridge                csr
);

	bridge_state_e state;
	bridge_state_e state_nxt;

	logic [DATA_W-1:0] csr_dr;

	// Slaves drive zero unless addressed, so a plain OR combines them
	assign csr_dr = csr.dr_gpio | csr.dr_timer;

	// ----------------------------------------------------------------------
	// FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (wb_cyc_i && wb_stb_i) begin
					if (wb_we_i)
						state_nxt = ST_WRITE;
					else
						state_nxt = ST_READ;
				end
			end
			ST_WRITE:
				state_nxt = ST_ACK;
			// Slaves register their read data during this cycle
			ST_READ:
				state_nxt = ST_READ_WAIT;
			ST_READ_WAIT:
				state_nxt = ST_ACK;
			// Master drops stb on the ack edge, back to idle
			ST_ACK:
				state_nxt = ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	// ----------------------------------------------------------------------
	// Address, write data and read data registers
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		// Sampled while idle, frozen for the rest of the transfer
		if (state == ST_IDLE) begin
			csr.csr_a <= wb_adr_i[CSR_ADDR_LSB +: CSR_ADDR_W];
			csr.csr_dw <= wb_dat_i;
		end
		if (state == ST_READ_WAIT)
			wb_dat_o <= csr_dr;
	end

	// Single-cycle strobes straight from the state
	assign csr.csr_we = (state == ST_WRITE);
	assign wb_ack_o = (state == ST_ACK);

endmodule

`default_nettype wire

// ==== hdl/csr_if.sv ====
`default_nettype none

interface csr_if
	import soc_pkg::*;
();

	logic [CSR_ADDR_W-1:0] csr_a;
	logic                  csr_we;
	logic [DATA_W-1:0]     csr_dw;

	// One read-data line per slave, zero when not selected
	logic [DATA_W-1:0]     dr_gpio;
	logic [DATA_W-1:0]     dr_timer;

	modport bridge (
		output csr_a, csr_we, csr_dw,
		input  dr_gpio, dr_timer
	);

	modport gpio (
		input  csr_a, csr_we, csr_dw,
		output dr_gpio
	);

	modport timer (
		input  csr_a, csr_we, csr_dw,
		output dr_timer
	);

endinterface

`default_nettype wire

// ==== hdl/reset_sequencer.sv ====
`default_nettype none

module reset_sequencer
	import soc_pkg::*;
(
	input  wire  sys_clk,
	input  wire  trigger_reset,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	logic [RST_CNT_W-1:0]       rst_cnt;
	logic [FLASH_RST_CNT_W-1:0] flash_cnt;

	// ----------------------------------------------------------------------
	// System reset stretch
	// ----------------------------------------------------------------------
	// Reload on every request, then count down to zero
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			rst_cnt <= '1;
			sys_rst_o <= 1'b1;
		end else begin
			if (rst_cnt != '0)
				rst_cnt <= rst_cnt - 1'b1;
			sys_rst_o <= (rst_cnt != '0);
		end
	end

	// ----------------------------------------------------------------------
	// Boot flash reset
	// ----------------------------------------------------------------------
	// Much shorter than the system stretch, so the flash is out of
	// reset and readable before the first instruction fetch
	always_ff @(posedge sys_clk) begin
		if (trigger_reset)
			flash_cnt <= '0;
		else if (!flash_cnt[FLASH_RST_CNT_W-1])
			flash_cnt <= flash_cnt + 1'b1;
	end

	// Top bit sticks once set
	assign flash_rst_n_o = flash_cnt[FLASH_RST_CNT_W-1];

endmodule

`default_nettype wire

// ==== hdl/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	// ----------------------------------------------------------------------
	// Bus widths
	// ----------------------------------------------------------------------
	localparam int WB_ADDR_W = 32;
	localparam int DATA_W = 32;

	// CSR word address comes from byte address bits 15:2
	localparam int CSR_ADDR_W = 14;
	localparam int CSR_ADDR_LSB = 2;

	// ----------------------------------------------------------------------
	// Bank map and register offsets
	// ----------------------------------------------------------------------
	// Bank field is the top of the CSR word address
	localparam int CSR_BANK_W = 4;
	localparam logic [CSR_BANK_W-1:0] CSR_BANK_SYSCTL = 4'd1;

	// Offset within a bank, low CSR address bits
	localparam int REG_OFS_W = 4;

	typedef enum logic [REG_OFS_W-1:0] {
		REG_GPIO_IN       = 4'd0,
		REG_GPIO_OUT      = 4'd1,
		REG_GPIO_IRQ_EN   = 4'd2,
		REG_SYSTEM_ID     = 4'd3,
		REG_TIMER_CTRL    = 4'd4,
		REG_TIMER_COMPARE = 4'd5,
		REG_TIMER_COUNTER = 4'd6
	} sysctl_reg_e;

	// ----------------------------------------------------------------------
	// System controller
	// ----------------------------------------------------------------------
	// Board revision nibble plus three buttons
	localparam int GPIO_IN_W = 7;
	// Two LEDs
	localparam int GPIO_OUT_W = 2;
	// Reads as "MONE"
	localparam logic [DATA_W-1:0] SYSTEM_ID = 32'h4D4F_4E45;

	localparam int TIMER_CTRL_EN_BIT = 0;
	localparam int TIMER_CTRL_AR_BIT = 1;

	// Bit 0 GPIO, bit 1 timer
	localparam int IRQ_W = 2;

	// Reset stretch lengths
	localparam int RST_CNT_W = 10;
	localparam int FLASH_RST_CNT_W = 8;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ,
		ST_READ_WAIT,
		ST_ACK
	} bridge_state_e;

endpackage

`default_nettype wire

// ==== hdl/sysctl_gpio.sv ====
`default_nettype none

module sysctl_gpio
	import soc_pkg::*;
(
	input  wire                   sys_clk,
	input  wire                   sys_rst_i,
	input  wire [GPIO_IN_W-1:0]   gpio_inputs_i,
	output logic [GPIO_OUT_W-1:0] gpio_outputs_o,
	output logic                  irq_o,
	csr_if.gpio                   csr
);

	logic [GPIO_IN_W-1:0] gpio_in_meta;
	logic [GPIO_IN_W-1:0] gpio_in_sync;
	logic [GPIO_IN_W-1:0] gpio_in_prev;
	logic [GPIO_IN_W-1:0] irq_en;

	logic        bank_sel;
	sysctl_reg_e reg_ofs;

	assign bank_sel = (csr.csr_a[CSR_ADDR_W-1 -: CSR_BANK_W] == CSR_BANK_SYSCTL);
	assign reg_ofs = sysctl_reg_e'(csr.csr_a[REG_OFS_W-1:0]);

	// ----------------------------------------------------------------------
	// Input synchronizer and change detect
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_in_meta <= gpio_inputs_i;
		gpio_in_sync <= gpio_in_meta;
		gpio_in_prev <= gpio_in_sync;
	end

	// Pulse on any enabled bit that changed
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			irq_o <= 1'b0;
		else
			irq_o <= |((gpio_in_sync ^ gpio_in_prev) & irq_en);
	end

	// ----------------------------------------------------------------------
	// Register writes
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_outputs_o <= '0;
			irq_en <= '0;
		end else if (csr.csr_we && bank_sel) begin
			case (reg_ofs)
				REG_GPIO_OUT:
					gpio_outputs_o <= csr.csr_dw[GPIO_OUT_W-1:0];
				REG_GPIO_IRQ_EN:
					irq_en <= csr.csr_dw[GPIO_IN_W-1:0];
				default: ;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Register reads
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		csr.dr_gpio <= '0;
		if (bank_sel) begin
			case (reg_ofs)
				REG_GPIO_IN:
					csr.dr_gpio <= DATA_W'(gpio_in_sync);
				REG_GPIO_OUT:
					csr.dr_gpio <= DATA_W'(gpio_outputs_o);
				REG_GPIO_IRQ_EN:
					csr.dr_gpio <= DATA_W'(irq_en);
				REG_SYSTEM_ID:
					csr.dr_gpio <= SYSTEM_ID;
				// Timer offsets answer from the timer
				default:
					csr.dr_gpio <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sysctl_soc.sv ====
`default_nettype none

module sysctl_soc
	import soc_pkg::*;
(
	input  wire                   sys_clk,
	input  wire                   trigger_reset,

	// Bus slave port
	input  wire [WB_ADDR_W-1:0]   wb_adr_i,
	input  wire [DATA_W-1:0]      wb_dat_i,
	input  wire                   wb_cyc_i,
	input  wire                   wb_stb_i,
	input  wire                   wb_we_i,
	output logic [DATA_W-1:0]     wb_dat_o,
	output logic                  wb_ack_o,

	// Buttons, board revision and LEDs
	input  wire [GPIO_IN_W-1:0]   gpio_inputs_i,
	output logic [GPIO_OUT_W-1:0] gpio_outputs_o,

	output logic [IRQ_W-1:0]      irq_o,
	output logic                  flash_rst_n_o,
	output logic                  periph_rst_n_o
);

	logic sys_rst;
	logic gpio_irq;
	logic timer_irq;

	csr_if csr_bus ();

	// ----------------------------------------------------------------------
	// Reset generation
	// ----------------------------------------------------------------------
	reset_sequencer u_reset_sequencer (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.sys_rst_o     (sys_rst),
		.flash_rst_n_o (flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	// ----------------------------------------------------------------------
	// Bus to CSR bridge and system-control bank
	// ----------------------------------------------------------------------
	csr_bridge u_csr_bridge (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.csr       (csr_bus.bridge)
	);

	sysctl_gpio u_sysctl_gpio (
		.sys_clk        (sys_clk),
		.sys_rst_i      (sys_rst),
		.gpio_inputs_i  (gpio_inputs_i),
		.gpio_outputs_o (gpio_outputs_o),
		.irq_o          (gpio_irq),
		.csr            (csr_bus.gpio)
	);

	sysctl_timer u_sysctl_timer (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.irq_o     (timer_irq),
		.csr       (csr_bus.timer)
	);

	assign irq_o = {timer_irq, gpio_irq};

endmodule

`default_nettype wire

// ==== hdl/sysctl_timer.sv ====
`default_nettype none

module sysctl_timer
	import soc_pkg::*;
(
	input  wire  sys_clk,
	input  wire  sys_rst_i,
	output logic irq_o,
	csr_if.timer csr
);

	logic              en;
	logic              autorestart;
	logic [DATA_W-1:0] compare;
	logic [DATA_W-1:0] counter;

	logic        bank_sel;
	logic        reg_wr;
	sysctl_reg_e reg_ofs;

	assign bank_sel = (csr.csr_a[CSR_ADDR_W-1 -: CSR_BANK_W] == CSR_BANK_SYSCTL);
	assign reg_ofs = sysctl_reg_e'(csr.csr_a[REG_OFS_W-1:0]);
	assign reg_wr = csr.csr_we && bank_sel;

	// ----------------------------------------------------------------------
	// Counter, match and register writes
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			en <= 1'b0;
			autorestart <= 1'b0;
			compare <= '0;
			counter <= '0;
			irq_o <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			if (en) begin
				if (counter == compare) begin
					counter <= '0;
					irq_o <= 1'b1;
					// One-shot stops here
					if (!autorestart)
						en <= 1'b0;
				end else begin
					counter <= counter + 1'b1;
				end
			end

			// Bus writes win over the count
			if (reg_wr) begin
				case (reg_ofs)
					REG_TIMER_CTRL: begin
						en <= csr.csr_dw[TIMER_CTRL_EN_BIT];
						autorestart <= csr.csr_dw[TIMER_CTRL_AR_BIT];
					end
					REG_TIMER_COMPARE:
						compare <= csr.csr_dw;
					REG_TIMER_COUNTER:
						counter <= csr.csr_dw;
					default: ;
				endcase
			end
		end
	end

	// ----------------------------------------------------------------------
	// Register reads
	// ----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		csr.dr_timer <= '0;
		if (bank_sel) begin
			case (reg_ofs)
				REG_TIMER_CTRL: begin
					csr.dr_timer[TIMER_CTRL_EN_BIT] <= en;
					csr.dr_timer[TIMER_CTRL_AR_BIT] <= autorestart;
				end
				REG_TIMER_COMPARE:
					csr.dr_timer <= compare;
				REG_TIMER_COUNTER:
					csr.dr_timer <= counter;
				default:
					csr.dr_timer <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+bench
hdl/soc_pkg.sv
hdl/csr_if.sv
hdl/reset_sequencer.sv
hdl/csr_bridge.sv
hdl/sysctl_gpio.sv
hdl/sysctl_timer.sv
hdl/sysctl_soc.sv
bench/tb_sysctl_soc.sv
